// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_window_map -o tb_window_map

run: compile
	./obj_dir/tb_window_map | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer import ppu_fetch_pkg::*; #(
	parameter int LINE_PIXELS = 160
) (
	input  logic clk,
	input  logic reset,
	input  logic line_start,
	input  logic win_start,
	output pix_t pix_x,
	output logic pix_valid,
	output logic fetch_due,
	output logic line_busy
);

	localparam pix_t LAST_PIX = pix_t'(LINE_PIXELS - 1);

	seq_state_t state;
	pix_t       pix_cnt;
	logic [TILE_PHASE_W-1:0] tile_phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			pix_cnt    <= '0;
			tile_phase <= '0;
		end else begin
			case (state)
				IDLE: begin
					// busy lines drop extra line starts.
					if (line_start) begin
						state      <= RENDER;
						pix_cnt    <= '0;
						tile_phase <= '0;
					end
				end
				RENDER: begin
					if (pix_cnt == LAST_PIX) begin
						state   <= IDLE;
						pix_cnt <= '0;
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
					// phase restarts with the window, this cycle counts as phase 0.
					if (win_start) begin
						tile_phase <= TILE_PHASE_W'(1);
					end else begin
						tile_phase <= tile_phase + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign pix_valid = (state == RENDER);
	assign line_busy = pix_valid;
	assign pix_x     = pix_cnt;

	// one map fetch per tile.
	assign fetch_due = pix_valid && (win_start || (tile_phase == '0));

endmodule

// File: lcd_reg_file.sv
`timescale 1ns/1ps

module lcd_reg_file import ppu_regs_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      reg_we,
	input  reg_addr_t reg_addr,
	input  reg_data_t reg_wdata,
	output lcd_ctrl_t ctrl,
	output scroll_t   scroll,
	output win_pos_t  win_pos
);

	lcd_ctrl_t ctrl_q;
	scroll_t   scroll_q;
	win_pos_t  win_pos_q;
	lcd_ctrl_t ctrl_wr;

	// keep the three control bits used by the map fetch.
	always_comb begin
		ctrl_wr.win_map_sel = reg_wdata[LCDC_WIN_MAP_BIT];
		ctrl_wr.win_en      = reg_wdata[LCDC_WIN_EN_BIT];
		ctrl_wr.bg_map_sel  = reg_wdata[LCDC_BG_MAP_BIT];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q    <= '0;
			scroll_q  <= '0;
			win_pos_q <= '0;
		end else if (reg_we) begin
			case (reg_addr)
				REG_LCDC: begin
					ctrl_q <= ctrl_wr;
				end
				REG_SCY: begin
					scroll_q.scy <= reg_wdata;
				end
				REG_SCX: begin
					scroll_q.scx <= reg_wdata;
				end
				REG_WY: begin
					win_pos_q.wy <= reg_wdata;
				end
				REG_WX: begin
					win_pos_q.wx <= reg_wdata;
				end
				// other addresses belong to other blocks.
				default: ;
			endcase
		end
	end

	assign ctrl    = ctrl_q;
	assign scroll  = scroll_q;
	assign win_pos = win_pos_q;

endmodule

// File: map_address_gen.sv
`timescale 1ns/1ps

module map_address_gen import ppu_regs_pkg::*, ppu_fetch_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  lcd_ctrl_t  ctrl,
	input  scroll_t    scroll,
	input  pix_t       ly,
	input  pix_t       pix_x,
	input  pix_t       win_line,
	input  logic       win_active,
	input  logic       fetch_due,
	output vram_addr_t map_addr,
	output logic       map_rd,
	output logic       map_is_window
);

	fetch_req_t req;
	pix_t       bg_y;
	pix_t       bg_x;
	tile_idx_t  win_col;
	vram_addr_t map_base;
	vram_addr_t req_addr;

	// wraps at 256.
	assign bg_y = ly + scroll.scy;
	assign bg_x = pix_x + scroll.scx;

	always_comb begin
		req.is_window = win_active;
		if (win_active) begin
			req.map_sel = ctrl.win_map_sel;
			req.row     = win_line[7:3];
			req.col     = win_col;
		end else begin
			req.map_sel = ctrl.bg_map_sel;
			req.row     = bg_y[7:3];
			req.col     = bg_x[7:3];
		end
	end

	assign map_base = req.map_sel ? MAP1_BASE : MAP0_BASE;

	// row times 32 plus column.
	assign req_addr = map_base + vram_addr_t'({req.row, req.col});

	// window column held at zero until the window opens.
	always_ff @(posedge clk) begin
		if (reset || !win_active) begin
			win_col <= '0;
		end else if (fetch_due) begin
			win_col <= win_col + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			map_rd        <= 1'b0;
			map_is_window <= 1'b0;
			map_addr      <= '0;
		end else begin
			map_rd <= fetch_due;
			if (fetch_due) begin
				map_is_window <= req.is_window;
				map_addr      <= req_addr;
			end
		end
	end

endmodule

// File: ppu_fetch_pkg.sv
package ppu_fetch_pkg;

	// pixel column or line number.
	typedef logic [7:0] pix_t;

	// tile row or column within a 32 by 32 map.
	typedef logic [4:0] tile_idx_t;

	// video memory address.
	typedef logic [12:0] vram_addr_t;

	typedef struct packed {
		logic      is_window;
		logic      map_sel;
		tile_idx_t row;
		tile_idx_t col;
	} fetch_req_t;

	// the two tile maps.
	localparam vram_addr_t MAP0_BASE = 13'h1800;
	localparam vram_addr_t MAP1_BASE = 13'h1C00;

	// pixels per tile, as a phase counter width.
	localparam int TILE_PHASE_W = 3;

	typedef enum logic {
		IDLE,
		RENDER
	} seq_state_t;

endpackage

// File: ppu_regs_pkg.sv
package ppu_regs_pkg;

	// low nibble of the register address.
	typedef logic [3:0] reg_addr_t;

	// register write data.
	typedef logic [7:0] reg_data_t;

	localparam reg_addr_t REG_LCDC = 4'd0;
	localparam reg_addr_t REG_SCY  = 4'd2;
	localparam reg_addr_t REG_SCX  = 4'd3;
	localparam reg_addr_t REG_WY   = 4'd10;
	localparam reg_addr_t REG_WX   = 4'd11;

	// bit positions inside the control register.
	localparam int LCDC_WIN_MAP_BIT = 6;
	localparam int LCDC_WIN_EN_BIT  = 5;
	localparam int LCDC_BG_MAP_BIT  = 3;

	// only the control bits this path looks at.
	typedef struct packed {
		logic win_map_sel;
		logic win_en;
		logic bg_map_sel;
	} lcd_ctrl_t;

	typedef struct packed {
		reg_data_t scy;
		reg_data_t scx;
	} scroll_t;

	typedef struct packed {
		reg_data_t wy;
		reg_data_t wx;
	} win_pos_t;

	// window X is offset by seven pixels on the screen.
	localparam reg_data_t WX_OFFSET = 8'd7;

endpackage

// File: tb.f
ppu_regs_pkg.sv
ppu_fetch_pkg.sv
lcd_reg_file.sv
window_trigger.sv
fetch_sequencer.sv
map_address_gen.sv
window_map_top.sv
tb_window_map.sv

// File: tb_window_map.sv
`timescale 1ns/1ps

module tb_window_map;

	localparam int LINE_PIXELS = 160;

	logic        clk;
	logic        reset;
	logic        reg_we;
	logic [3:0]  reg_addr;
	logic [7:0]  reg_wdata;
	logic [7:0]  ly;
	logic        line_start;
	logic        vblank;
	logic [12:0] map_addr;
	logic        map_rd;
	logic        map_is_window;
	logic        win_active;
	logic        line_busy;

	// register copies and window state of the reference model.
	logic [7:0]  r_ctrl;
	logic [7:0]  r_scy;
	logic [7:0]  r_scx;
	logic [7:0]  r_wy;
	logic [7:0]  r_wx;
	logic        m_wy_match;
	logic        m_win_used;
	logic [7:0]  m_win_line;
	logic [31:0] rng;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic [12:0] got_addr[$];
	logic        got_win[$];
	int          got_cyc[$];

	window_map_top #(
		.LINE_PIXELS (LINE_PIXELS)
	) DUT (
		.clk           (clk),
		.reset         (reset),
		.reg_we        (reg_we),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.ly            (ly),
		.line_start    (line_start),
		.vblank        (vblank),
		.map_addr      (map_addr),
		.map_rd        (map_rd),
		.map_is_window (map_is_window),
		.win_active    (win_active),
		.line_busy     (line_busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] next_rand();
		rng = xorshift32(rng);
		return rng[7:0];
	endfunction

	// map base plus row times 32 plus column.
	function automatic logic [12:0] tile_addr(input logic sel, input logic [4:0] row,
		input logic [4:0] col);
		return (sel ? 13'h1C00 : 13'h1800) + {3'b000, row, 5'b00000} + {8'h00, col};
	endfunction

	task automatic mismatch(input string msg);
		errors++;
		$display("[ERROR] time %0t: %s", $time, msg);
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
		@(posedge clk);
		reg_we    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge clk);
		reg_we <= 1'b0;
		case (a)
			4'd0: r_ctrl = d;
			4'd2: r_scy = d;
			4'd3: r_scx = d;
			4'd10: r_wy = d;
			4'd11: r_wx = d;
			default: ;
		endcase
	endtask

	task automatic pulse_vblank();
		@(posedge clk);
		vblank <= 1'b1;
		@(posedge clk);
		vblank <= 1'b0;
		m_wy_match = 1'b0;
		m_win_used = 1'b0;
		m_win_line = '0;
	endtask

	// runs one line, poke_at >= 0 adds a stray line start at that pixel.
	task automatic run_line(input logic [7:0] line, input int poke_at);
		logic [12:0] exp_addr[$];
		logic        exp_win[$];
		int          exp_cyc[$];
		logic        win_on;
		int          wstart;
		logic [4:0]  wcol;
		logic [7:0]  bx;
		logic [7:0]  by;
		int          cyc;
		int          first_win;
		int          busy_cnt;
		int          win_cnt;
		logic        seen_busy;
		logic        done;
		if (m_win_used) begin
			m_win_line = m_win_line + 8'd1;
		end
		if (r_ctrl[5] && r_wy == line) begin
			m_wy_match = 1'b1;
		end
		wstart = int'(r_wx) - 7;
		win_on = m_wy_match && r_ctrl[5] && wstart >= 0 && wstart < LINE_PIXELS;
		m_win_used = win_on;
		wcol = '0;
		by = line + r_scy;
		for (int x = 0; x < LINE_PIXELS; x++) begin
			if (win_on && x >= wstart) begin
				if ((x - wstart) % 8 == 0) begin
					exp_addr.push_back(tile_addr(r_ctrl[6], m_win_line[7:3], wcol));
					exp_win.push_back(1'b1);
					exp_cyc.push_back(x + 1);
					wcol = wcol + 5'd1;
				end
			end else if (x % 8 == 0) begin
				bx = 8'(x) + r_scx;
				exp_addr.push_back(tile_addr(r_ctrl[3], by[7:3], bx[7:3]));
				exp_win.push_back(1'b0);
				exp_cyc.push_back(x + 1);
			end
		end
		got_addr.delete();
		got_win.delete();
		got_cyc.delete();
		@(posedge clk);
		ly         <= line;
		line_start <= 1'b1;
		@(posedge clk);
		line_start <= 1'b0;
		cyc = 0;
		first_win = -1;
		busy_cnt = 0;
		win_cnt = 0;
		seen_busy = 1'b0;
		done = 1'b0;
		while (!done && cyc < LINE_PIXELS + 20) begin
			@(negedge clk);
			if (cyc == 0 && !line_busy) begin
				mismatch("line_busy low at pixel 0");
			end
			if (line_busy) begin
				seen_busy = 1'b1;
				busy_cnt++;
			end
			if (win_active) begin
				win_cnt++;
				if (first_win < 0) begin
					first_win = cyc;
				end
			end
			if (map_rd) begin
				got_addr.push_back(map_addr);
				got_win.push_back(map_is_window);
				got_cyc.push_back(cyc);
			end
			if (seen_busy && !line_busy) begin
				done = 1'b1;
			end
			cyc++;
			@(posedge clk);
			line_start <= (cyc == poke_at);
		end
		if (!done) begin
			errors++;
			$display("timeout: line %0d did not end within %0d cycles", line, LINE_PIXELS + 20);
		end
		if (busy_cnt != LINE_PIXELS) begin
			mismatch($sformatf("line_busy high %0d cycles, expected %0d", busy_cnt, LINE_PIXELS));
		end
		if (win_on && (first_win != wstart || win_cnt != LINE_PIXELS - wstart)) begin
			mismatch($sformatf("win_active rose at %0d for %0d cycles, expected %0d",
				first_win, win_cnt, wstart));
		end
		if (!win_on && first_win >= 0) begin
			mismatch($sformatf("win_active high at pixel %0d on a line without window",
				first_win));
		end
		if (got_addr.size() != exp_addr.size()) begin
			mismatch($sformatf("line %0d gave %0d fetches, expected %0d", line,
				got_addr.size(), exp_addr.size()));
		end else begin
			foreach (exp_addr[i]) begin
				if (got_addr[i] != exp_addr[i] || got_win[i] != exp_win[i] ||
					got_cyc[i] != exp_cyc[i]) begin
					mismatch($sformatf("fetch %0d: addr %h win %0b cycle %0d, expected %h %0b %0d",
						i, got_addr[i], got_win[i], got_cyc[i], exp_addr[i], exp_win[i],
						exp_cyc[i]));
				end
			end
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		@(negedge clk);
		if (line_busy || map_rd || win_active) begin
			mismatch("outputs not low after reset");
		end
		run_line(8'd0, -1);
		if (got_addr.size() != 20) begin
			mismatch($sformatf("%0d fetches on the first line, expected 20", got_addr.size()));
		end
		foreach (got_addr[i]) begin
			if (got_addr[i] != 13'h1800 + 13'(i)) begin
				mismatch($sformatf("fetch %0d at %h", i, got_addr[i]));
			end
		end
		finish_test("reset state", e);
	endtask

	task automatic test_bg_scroll();
		int e;
		e = errors;
		for (int i = 0; i < 3; i++) begin
			write_reg(4'd3, next_rand());
			write_reg(4'd2, next_rand());
			run_line(next_rand(), -1);
		end
		write_reg(4'd0, 8'h08);
		run_line(next_rand(), -1);
		if (got_addr.size() == 0 || got_addr[0] < 13'h1C00) begin
			mismatch("bg_map_sel did not move the map base");
		end
		finish_test("background scroll", e);
	endtask

	task automatic test_window_start();
		int e;
		logic [7:0] wy;
		e = errors;
		pulse_vblank();
		write_reg(4'd0, (next_rand() & 8'h40) | 8'h20);
		wy = next_rand() % 8'd144;
		write_reg(4'd10, wy);
		write_reg(4'd11, 8'd7 + (next_rand() % 8'd160));
		run_line(wy, -1);
		run_line(wy + 8'd1, -1);
		finish_test("window start", e);
	endtask

	task automatic test_window_lines();
		int e;
		logic [7:0] wy;
		e = errors;
		pulse_vblank();
		write_reg(4'd0, 8'h20);
		wy = next_rand() % 8'd100;
		write_reg(4'd10, wy);
		write_reg(4'd11, 8'd7 + (next_rand() % 8'd160));
		// lines 3 and 7 skip the window, so the row reaches 1 near the end.
		for (int i = 0; i < 12; i++) begin
			if (i == 3 || i == 7) begin
				write_reg(4'd0, 8'h00);
			end
			run_line(wy + 8'(i), -1);
			if (i == 3 || i == 7) begin
				write_reg(4'd0, 8'h20);
			end
		end
		pulse_vblank();
		write_reg(4'd10, wy + 8'd20);
		run_line(wy + 8'd20, -1);
		finish_test("window line counter", e);
	endtask

	task automatic test_no_window();
		int e;
		e = errors;
		pulse_vblank();
		write_reg(4'd0, 8'h48);
		write_reg(4'd10, 8'd20);
		write_reg(4'd11, 8'd50);
		run_line(8'd20, -1);
		write_reg(4'd0, 8'h60);
		write_reg(4'd10, 8'd200);
		for (int i = 0; i < 4; i++) begin
			run_line(8'd10 + 8'(i), -1);
		end
		finish_test("window disabled", e);
	endtask

	task automatic test_reg_decode();
		int e;
		e = errors;
		write_reg(4'd2, next_rand());
		write_reg(4'd3, next_rand());
		for (int a = 1; a < 16; a++) begin
			if (a != 2 && a != 3 && a != 10 && a != 11) begin
				write_reg(4'(a), next_rand());
			end
		end
		run_line(next_rand() % 8'd144, -1);
		run_line(next_rand() % 8'd144, 60);
		if (got_addr.size() != 20) begin
			mismatch($sformatf("%0d fetches with a stray line start", got_addr.size()));
		end
		finish_test("register decode", e);
	endtask

	initial begin
		reset = 1'b1;
		reg_we = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		ly = '0;
		line_start = 1'b0;
		vblank = 1'b0;
		r_ctrl = '0;
		r_scy = '0;
		r_scx = '0;
		r_wy = '0;
		r_wx = '0;
		m_wy_match = 1'b0;
		m_win_used = 1'b0;
		m_win_line = '0;
		rng = 32'h9521;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_reset_state();
		test_bg_scroll();
		test_window_start();
		test_window_lines();
		test_no_window();
		test_reg_decode();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: window_map_top.sv
`timescale 1ns/1ps

module window_map_top import ppu_regs_pkg::*, ppu_fetch_pkg::*; #(
	parameter int LINE_PIXELS = 160
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       reg_we,
	input  reg_addr_t  reg_addr,
	input  reg_data_t  reg_wdata,
	input  pix_t       ly,
	input  logic       line_start,
	input  logic       vblank,
	output vram_addr_t map_addr,
	output logic       map_rd,
	output logic       map_is_window,
	output logic       win_active,
	output logic       line_busy
);

	lcd_ctrl_t ctrl;
	scroll_t   scroll;
	win_pos_t  win_pos;
	pix_t      pix_x;
	logic      pix_valid;
	logic      fetch_due;
	logic      win_start;
	pix_t      win_line;

	lcd_reg_file u_regs (
		.clk       (clk),
		.reset     (reset),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.ctrl      (ctrl),
		.scroll    (scroll),
		.win_pos   (win_pos)
	);

	window_trigger #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_trigger (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.win_pos    (win_pos),
		.ly         (ly),
		.line_start (line_start),
		.vblank     (vblank),
		.pix_x      (pix_x),
		.pix_valid  (pix_valid),
		.win_active (win_active),
		.win_start  (win_start),
		.win_line   (win_line)
	);

	fetch_sequencer #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_seq (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.win_start  (win_start),
		.pix_x      (pix_x),
		.pix_valid  (pix_valid),
		.fetch_due  (fetch_due),
		.line_busy  (line_busy)
	);

	map_address_gen u_addr (
		.clk           (clk),
		.reset         (reset),
		.ctrl          (ctrl),
		.scroll        (scroll),
		.ly            (ly),
		.pix_x         (pix_x),
		.win_line      (win_line),
		.win_active    (win_active),
		.fetch_due     (fetch_due),
		.map_addr      (map_addr),
		.map_rd        (map_rd),
		.map_is_window (map_is_window)
	);

endmodule

// File: window_trigger.sv
`timescale 1ns/1ps

module window_trigger import ppu_regs_pkg::*, ppu_fetch_pkg::*; #(
	parameter int LINE_PIXELS = 160
) (
	input  logic      clk,
	input  logic      reset,
	input  lcd_ctrl_t ctrl,
	input  win_pos_t  win_pos,
	input  pix_t      ly,
	input  logic      line_start,
	input  logic      vblank,
	input  pix_t      pix_x,
	input  logic      pix_valid,
	output logic      win_active,
	output logic      win_start,
	output pix_t      win_line
);

	localparam pix_t LAST_PIX = pix_t'(LINE_PIXELS - 1);

	logic       wy_match;
	logic       win_active_q;
	logic       win_used;
	pix_t       win_line_q;
	logic       start_ok;
	logic       wy_hit;
	logic [8:0] wx_pos;
	logic       wx_hit;
	logic       line_end;

	// a line start is only taken between lines.
	assign start_ok = line_start && !pix_valid;

	assign wy_hit = ctrl.win_en && (win_pos.wy == ly);

	// compare in nine bits so pixel plus seven cannot wrap.
	assign wx_pos = {1'b0, pix_x} + {1'b0, WX_OFFSET};
	assign wx_hit = (win_pos.wx >= WX_OFFSET) && (wx_pos == {1'b0, win_pos.wx});

	assign line_end = pix_valid && (pix_x == LAST_PIX);

	assign win_start = pix_valid && wy_match && ctrl.win_en && wx_hit && !win_active_q;

	// rises in the start cycle itself.
	assign win_active = win_active_q || win_start;

	always_ff @(posedge clk) begin
		if (reset) begin
			wy_match <= 1'b0;
		end else if (vblank) begin
			wy_match <= 1'b0;
		end else if (start_ok && wy_hit) begin
			// held for the rest of the frame.
			wy_match <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			win_active_q <= 1'b0;
		end else if (line_end) begin
			win_active_q <= 1'b0;
		end else if (win_start) begin
			win_active_q <= 1'b1;
		end
	end

	// line counter only advances past a line that showed the window.
	always_ff @(posedge clk) begin
		if (reset) begin
			win_used   <= 1'b0;
			win_line_q <= '0;
		end else if (vblank) begin
			win_used   <= 1'b0;
			win_line_q <= '0;
		end else if (start_ok) begin
			win_used <= 1'b0;
			if (win_used) begin
				win_line_q <= win_line_q + 1'b1;
			end
		end else if (win_start) begin
			win_used <= 1'b1;
		end
	end

	assign win_line = win_line_q;

endmodule
